// File: list.f
rtl/wb_pkg.sv
rtl/soc_pkg.sv
rtl/servant_arbiter.sv
rtl/servant_mux.sv
rtl/servant_ram.sv
rtl/servant_timer.sv
rtl/servant_soc.sv
dv/servant_chk.sv
dv/servant_tb.sv

// File: Bender.yml
package:
  name: servant_soc

sources:
  # RTL
  - files:
      - rtl/wb_pkg.sv
      - rtl/soc_pkg.sv
      - rtl/servant_arbiter.sv
      - rtl/servant_mux.sv
      - rtl/servant_ram.sv
      - rtl/servant_timer.sv
      - rtl/servant_soc.sv
  - target: test
    files:
      - dv/servant_chk.sv
      - dv/servant_tb.sv

// File: dv/servant_tb.sv
`timescale 1ns/1ps

module servant_tb;

   localparam int CLK_NS     = 20;
   localparam int ACK_WAIT   = 4;
   localparam int N_RAM      = 200;
   localparam int N_ARB      = 8;
   localparam int N_GPIO     = 8;
   localparam int N_TIME     = 4;
   localparam int IRQ_DELTA  = 50;
   localparam int TIMER_WAIT = IRQ_DELTA + 8 * N_TIME + 20;
   localparam int N_ACCESS   = 2 + 4 * N_RAM + 2 * N_ARB + 3 * N_GPIO + 2 * N_TIME + 3;
   localparam int WATCHDOG_NS = (N_ACCESS * ACK_WAIT + TIMER_WAIT) * CLK_NS * 2;
   localparam wb_pkg::word_t GPIO_ADR  = {soc_pkg::SEL_GPIO, 30'd0};
   localparam wb_pkg::word_t TIMER_ADR = {soc_pkg::SEL_TIMER, 30'd0};

   logic            clk;
   logic            rst_n;
   wb_pkg::wb_req_t ibus_req;
   wb_pkg::wb_rsp_t ibus_rsp;
   wb_pkg::wb_req_t dbus_req;
   wb_pkg::wb_rsp_t dbus_rsp;
   logic            q;
   logic            timer_irq;

   integer          seed = 32'h57aae603;
   int              cyc_cnt = 0;
   int              rel_cnt = 0;
   int              err_cnt = 0;
   int              chk_cnt = 0;
   string           test_name = "init";
   wb_pkg::word_t   ref_mem [soc_pkg::MEM_WORDS];
   logic            gpio_ref = 1'b0;
   wb_pkg::word_t   addrs [N_RAM];

   servant_soc dut0 (
      .i_wb_clk    (clk),
      .i_rst_n     (rst_n),
      .i_ibus      (ibus_req),
      .o_ibus      (ibus_rsp),
      .i_dbus      (dbus_req),
      .o_dbus      (dbus_rsp),
      .o_q         (q),
      .o_timer_irq (timer_irq)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   always @(posedge clk) cyc_cnt <= cyc_cnt + 1;

   function automatic wb_pkg::word_t ref_mem_read(input wb_pkg::word_t adr);
      return ref_mem[adr[soc_pkg::MEM_AW-1:2]];
   endfunction

   function automatic void ref_write(input wb_pkg::wb_req_t req);
      int idx;
      idx = req.adr[soc_pkg::MEM_AW-1:2];
      if (req.adr[31:30] == soc_pkg::SEL_MEM) begin
         for (int i = 0; i < wb_pkg::SEL_W; i++) begin
            if (req.sel[i]) begin
               ref_mem[idx][i*wb_pkg::BYTE_W +: wb_pkg::BYTE_W] =
                  req.dat[i*wb_pkg::BYTE_W +: wb_pkg::BYTE_W];
            end
         end
      end else if (req.adr[31:30] == soc_pkg::SEL_GPIO) begin
         gpio_ref = req.dat[0];
      end
   endfunction

   // mtime counts from zero in the cycle where reset was released
   function automatic wb_pkg::word_t expected_rdt(input wb_pkg::wb_req_t req, input int cycle);
      wb_pkg::word_t res;
      case (req.adr[31:30])
         soc_pkg::SEL_MEM:  res = ref_mem_read(req.adr);
         soc_pkg::SEL_GPIO: res = wb_pkg::word_t'(gpio_ref);
         default:           res = wb_pkg::word_t'(cycle - rel_cnt);
      endcase
      return res;
   endfunction

   task automatic check_word(input string what, input wb_pkg::word_t exp,
                             input wb_pkg::word_t act);
      chk_cnt++;
      if (act !== exp) begin
         err_cnt++;
         $display("Fail %s/%s expected %h actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      chk_cnt++;
      if (act !== exp) begin
         err_cnt++;
         $display("Fail %s/%s expected %b actual %b", test_name, what, exp, act);
      end
   endtask

   task automatic check_latency(input string what, input int exp, input int act);
      chk_cnt++;
      if (act != exp) begin
         err_cnt++;
         $display("Fail %s/%s expected %0d actual %0d", test_name, what, exp, act);
      end
   endtask

   // Every ack is checked here while the request is still held
   always @(negedge clk) begin
      if (rst_n) begin
         if (ibus_rsp.ack) begin
            check_word("ibus_rdt", ref_mem_read(ibus_req.adr), ibus_rsp.rdt);
         end
         if (dbus_rsp.ack) begin
            if (dbus_req.we) begin
               ref_write(dbus_req);
            end else begin
               check_word("dbus_rdt", expected_rdt(dbus_req, cyc_cnt), dbus_rsp.rdt);
            end
         end
      end
   end

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic dbus_access(input wb_pkg::word_t adr, input wb_pkg::word_t dat,
                              input wb_pkg::sel_t sel, input logic we,
                              output wb_pkg::word_t rdt, output int ack_cyc, output int lat);
      int start;
      int waited;
      start   = cyc_cnt;
      waited  = 0;
      lat     = -1;
      ack_cyc = -1;
      rdt     = '0;
      dbus_req.adr = adr;
      dbus_req.dat = dat;
      dbus_req.sel = sel;
      dbus_req.we  = we;
      dbus_req.cyc = 1'b1;
      while (lat < 0 && waited < ACK_WAIT) begin
         @(negedge clk);
         waited++;
         if (dbus_rsp.ack) begin
            lat     = cyc_cnt - start;
            ack_cyc = cyc_cnt;
            rdt     = dbus_rsp.rdt;
         end
      end
      if (lat < 0) begin
         err_cnt++;
         $display("Data bus access to %h got no ack within %0d cycles", adr, ACK_WAIT);
      end
      @(posedge clk);
      #1;
      dbus_req.cyc = 1'b0;
      dbus_req.we  = 1'b0;
   endtask

   task automatic ibus_fetch(input wb_pkg::word_t adr, output wb_pkg::word_t rdt,
                             output int ack_cyc, output int lat);
      int start;
      int waited;
      start   = cyc_cnt;
      waited  = 0;
      lat     = -1;
      ack_cyc = -1;
      rdt     = '0;
      ibus_req.adr = adr;
      ibus_req.dat = '0;
      ibus_req.sel = '1;
      ibus_req.we  = 1'b0;
      ibus_req.cyc = 1'b1;
      while (lat < 0 && waited < ACK_WAIT) begin
         @(negedge clk);
         waited++;
         if (ibus_rsp.ack) begin
            lat     = cyc_cnt - start;
            ack_cyc = cyc_cnt;
            rdt     = ibus_rsp.rdt;
         end
      end
      if (lat < 0) begin
         err_cnt++;
         $display("Instruction fetch from %h got no ack within %0d cycles", adr, ACK_WAIT);
      end
      @(posedge clk);
      #1;
      ibus_req.cyc = 1'b0;
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns with the tests still running", WATCHDOG_NS);
      $display("Verification failed");
      $finish;
   end

   initial begin
      wb_pkg::word_t rdt;
      wb_pkg::word_t rdt2;
      wb_pkg::word_t m;
      wb_pkg::word_t d;
      wb_pkg::sel_t  sel;
      int            ack_cyc;
      int            ack2;
      int            lat;
      int            lat2;
      int            j;
      int            k;
      int            total;
      rst_n    = 1'b0;
      ibus_req = '0;
      dbus_req = '0;
      repeat (3) @(posedge clk);
      #1;
      rst_n   = 1'b1;
      rel_cnt = cyc_cnt;

      test_name = "reset";
      @(negedge clk);
      check_bit("o_q", 1'b0, q);
      check_bit("o_timer_irq", 1'b0, timer_irq);
      check_bit("ibus_ack", 1'b0, ibus_rsp.ack);
      check_bit("dbus_ack", 1'b0, dbus_rsp.ack);
      @(posedge clk);
      #1;
      dbus_access(32'h0000_0100, 32'hcafe_f00d, 4'hf, 1'b1, rdt, ack_cyc, lat);
      check_latency("dbus_first", 1, lat);
      ibus_fetch(32'h0000_0100, rdt, ack_cyc, lat);
      check_latency("ibus_first", 1, lat);

      test_name = "ram";
      for (int i = 0; i < N_RAM; i++) begin
         addrs[i] = $random(seed) & 32'h3fff_fffc;
         dbus_access(addrs[i], $random(seed), 4'hf, 1'b1, rdt, ack_cyc, lat);
         check_latency("full_write", 1, lat);
      end
      for (int i = 0; i < N_RAM; i++) begin
         sel = wb_pkg::sel_t'($random(seed));
         dbus_access(addrs[i], $random(seed), sel, 1'b1, rdt, ack_cyc, lat);
      end
      for (int i = 0; i < N_RAM; i++) begin
         dbus_access(addrs[i], '0, 4'hf, 1'b0, rdt, ack_cyc, lat);
         check_latency("read", 1, lat);
         ibus_fetch(addrs[i], rdt, ack_cyc, lat);
         check_latency("fetch", 1, lat);
      end

      test_name = "arbitration";
      for (int i = 0; i < N_ARB; i++) begin
         j = {$random(seed)} % N_RAM;
         k = {$random(seed)} % N_RAM;
         fork
            ibus_fetch(addrs[j], rdt, ack_cyc, lat);
            dbus_access(addrs[k], '0, 4'hf, 1'b0, rdt2, ack2, lat2);
         join
         check_latency("ibus_granted", 1, lat);
         check_latency("dbus_waits", 3, lat2); // Ack, drop, then the RAM's own cycle
      end

      test_name = "gpio";
      for (int i = 0; i < N_GPIO; i++) begin
         d = $random(seed);
         dbus_access(GPIO_ADR, d, 4'hf, 1'b1, rdt, ack_cyc, lat);
         check_latency("gpio_write", 1, lat);
         check_bit("o_q", d[0], q);
         dbus_access(GPIO_ADR, '0, 4'hf, 1'b0, rdt, ack_cyc, lat);
         j = {$random(seed)} % N_RAM;
         dbus_access(addrs[j], $random(seed), 4'hf, 1'b1, rdt, ack_cyc, lat);
         check_bit("o_q_after_ram", d[0], q);
      end

      test_name = "timer_count";
      for (int i = 0; i < N_TIME; i++) begin
         dbus_access(TIMER_ADR, '0, 4'hf, 1'b0, rdt, ack_cyc, lat);
         idle({$random(seed)} % 8);
         dbus_access(TIMER_ADR, '0, 4'hf, 1'b0, rdt2, ack2, lat2);
         check_latency("timer_read", 1, lat2);
         check_word("mtime_delta", wb_pkg::word_t'(ack2 - ack_cyc), rdt2 - rdt);
      end

      test_name = "timer_irq";
      dbus_access(TIMER_ADR, '0, 4'hf, 1'b0, m, k, lat);
      dbus_access(TIMER_ADR, m + IRQ_DELTA, 4'hf, 1'b1, rdt, ack_cyc, lat);
      while (cyc_cnt < k + IRQ_DELTA + 3) begin
         @(negedge clk);
         check_bit("o_timer_irq", cyc_cnt > k + IRQ_DELTA, timer_irq); // Registered compare
      end
      @(posedge clk);
      #1;
      dbus_access(TIMER_ADR, '1, 4'hf, 1'b1, rdt, ack_cyc, lat);
      @(negedge clk);
      check_bit("o_timer_irq_clear", 1'b0, timer_irq);

      total = err_cnt + dut0.chk0.fail_cnt;
      $display("Checks %0d, compare errors %0d, assertion failures %0d",
               chk_cnt, err_cnt, dut0.chk0.fail_cnt);
      if (total == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// File: dv/servant_chk.sv
`timescale 1ns/1ps

module servant_chk (
   input logic            i_wb_clk,
   input logic            i_rst_n,
   input wb_pkg::wb_req_t i_ibus_req,
   input wb_pkg::wb_rsp_t i_ibus_rsp,
   input wb_pkg::wb_req_t i_dbus_req,
   input wb_pkg::wb_rsp_t i_dbus_rsp
);

   int   fail_cnt = 0;
   logic both_mem;

   assign both_mem = i_ibus_req.cyc & i_dbus_req.cyc &
                     (i_dbus_req.adr[31:30] == soc_pkg::SEL_MEM);

   ibus_ack_after_cyc: assert property (@(posedge i_wb_clk) disable iff (!i_rst_n)
      i_ibus_rsp.ack |-> $past(i_ibus_req.cyc))
      else begin
         fail_cnt++;
         $error("Instruction bus ack without cyc in the previous cycle");
      end

   dbus_ack_after_cyc: assert property (@(posedge i_wb_clk) disable iff (!i_rst_n)
      i_dbus_rsp.ack |-> $past(i_dbus_req.cyc))
      else begin
         fail_cnt++;
         $error("Data bus ack without cyc in the previous cycle");
      end

   ack_single_cycle: assert property (@(posedge i_wb_clk) disable iff (!i_rst_n)
      (i_ibus_rsp.ack || i_dbus_rsp.ack) |=> !(($past(i_ibus_rsp.ack) && i_ibus_rsp.ack) ||
                                               ($past(i_dbus_rsp.ack) && i_dbus_rsp.ack)))
      else begin
         fail_cnt++;
         $error("An ack stayed high for two cycles");
      end

   // Holds from the first edge that sees reset
   ack_low_after_reset: assert property (@(posedge i_wb_clk)
      !i_rst_n |=> (!i_ibus_rsp.ack && !i_dbus_rsp.ack))
      else begin
         fail_cnt++;
         $error("An ack was high right after reset");
      end

   one_ram_ack: assert property (@(posedge i_wb_clk) disable iff (!i_rst_n)
      both_mem |-> !(i_ibus_rsp.ack && i_dbus_rsp.ack))
      else begin
         fail_cnt++;
         $error("Both buses were acked by the RAM in the same cycle");
      end

endmodule

bind servant_soc servant_chk chk0 (
   .i_wb_clk   (i_wb_clk),
   .i_rst_n    (i_rst_n),
   .i_ibus_req (i_ibus),
   .i_ibus_rsp (o_ibus),
   .i_dbus_req (i_dbus),
   .i_dbus_rsp (o_dbus)
);

// File: rtl/servant_soc.sv
`timescale 1ns/1ps

module servant_soc (
   input  logic            i_wb_clk,
   input  logic            i_rst_n,
   input  wb_pkg::wb_req_t i_ibus,
   output wb_pkg::wb_rsp_t o_ibus,
   input  wb_pkg::wb_req_t i_dbus,
   output wb_pkg::wb_rsp_t o_dbus,
   output logic            o_q,
   output logic            o_timer_irq
);

   wb_pkg::wb_req_t dmem_req;
   wb_pkg::wb_rsp_t dmem_rsp;
   wb_pkg::wb_req_t mem_req;
   wb_pkg::wb_rsp_t mem_rsp;
   wb_pkg::wb_req_t timer_req;
   wb_pkg::word_t   timer_rdt;

   servant_mux mux0 (
      .i_wb_clk    (i_wb_clk),
      .i_rst_n     (i_rst_n),
      .i_dbus      (i_dbus),
      .o_dbus      (o_dbus),
      .o_dmem      (dmem_req),
      .i_dmem      (dmem_rsp),
      .o_timer     (timer_req),
      .i_timer_rdt (timer_rdt),
      .o_q         (o_q)
   );

   // Single RAM port shared by fetch and load/store
   servant_arbiter arbiter0 (
      .i_ibus (i_ibus),
      .o_ibus (o_ibus),
      .i_dmem (dmem_req),
      .o_dmem (dmem_rsp),
      .o_mem  (mem_req),
      .i_mem  (mem_rsp)
   );

   servant_ram ram0 (
      .i_wb_clk (i_wb_clk),
      .i_rst_n  (i_rst_n),
      .i_mem    (mem_req),
      .o_mem    (mem_rsp)
   );

   servant_timer timer0 (
      .i_wb_clk (i_wb_clk),
      .i_rst_n  (i_rst_n),
      .i_timer  (timer_req),
      .o_rdt    (timer_rdt),
      .o_irq    (o_timer_irq)
   );

endmodule

// File: rtl/servant_timer.sv
`timescale 1ns/1ps

module servant_timer (
   input  logic            i_wb_clk,
   input  logic            i_rst_n,
   input  wb_pkg::wb_req_t i_timer,
   output wb_pkg::word_t   o_rdt,
   output logic            o_irq
);

   logic [soc_pkg::TIMER_W-1:0] mtime;
   logic [soc_pkg::TIMER_W-1:0] mtimecmp;
   logic                        irq_q;

   always_ff @(posedge i_wb_clk) begin
      if (!i_rst_n) begin
         mtime <= '0;
      end else begin
         mtime <= mtime + 1'b1; // Free running, wraps silently
      end
   end

   always_ff @(posedge i_wb_clk) begin
      if (!i_rst_n) begin
         mtimecmp <= soc_pkg::MTIMECMP_RST;
      end else if (i_timer.cyc & i_timer.we) begin
         mtimecmp <= i_timer.dat[soc_pkg::TIMER_W-1:0];
      end
   end

   always_ff @(posedge i_wb_clk) begin
      if (!i_rst_n) begin
         irq_q <= 1'b0;
      end else begin
         irq_q <= (mtime >= mtimecmp); // Unsigned compare
      end
   end

   assign o_rdt = wb_pkg::word_t'(mtime);
   assign o_irq = irq_q;

endmodule

// File: rtl/servant_ram.sv
`timescale 1ns/1ps

module servant_ram (
   input  logic            i_wb_clk,
   input  logic            i_rst_n,
   input  wb_pkg::wb_req_t i_mem,
   output wb_pkg::wb_rsp_t o_mem
);

   wb_pkg::word_t              mem [soc_pkg::MEM_WORDS];
   logic [soc_pkg::MEM_AW-3:0] waddr;
   wb_pkg::word_t              rdt_q;
   logic                       ack_q;
   logic                       wr_en;

   assign waddr = i_mem.adr[soc_pkg::MEM_AW-1:2]; // Byte address down to word index
   assign wr_en = i_mem.cyc & i_mem.we & ~ack_q;

   always_ff @(posedge i_wb_clk) begin
      if (wr_en) begin
         for (int i = 0; i < wb_pkg::SEL_W; i++) begin
            if (i_mem.sel[i]) begin
               mem[waddr][i*wb_pkg::BYTE_W +: wb_pkg::BYTE_W] <=
                  i_mem.dat[i*wb_pkg::BYTE_W +: wb_pkg::BYTE_W];
            end
         end
      end
      rdt_q <= mem[waddr];
   end

   // Held cyc after ack starts a fresh access one cycle later
   always_ff @(posedge i_wb_clk) begin
      if (!i_rst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= i_mem.cyc & ~ack_q;
      end
   end

   assign o_mem.rdt = rdt_q;
   assign o_mem.ack = ack_q;

endmodule

// File: rtl/servant_mux.sv
`timescale 1ns/1ps

module servant_mux (
   input  logic            i_wb_clk,
   input  logic            i_rst_n,
   input  wb_pkg::wb_req_t i_dbus,
   output wb_pkg::wb_rsp_t o_dbus,
   output wb_pkg::wb_req_t o_dmem,
   input  wb_pkg::wb_rsp_t i_dmem,
   output wb_pkg::wb_req_t o_timer,
   input  wb_pkg::word_t   i_timer_rdt,
   output logic            o_q
);

   logic [1:0] region;
   logic       hit_mem;
   logic       hit_gpio;
   logic       hit_timer;
   logic       periph_ack;
   logic       gpio_q;

   assign region    = i_dbus.adr[31:30];
   assign hit_mem   = (region == soc_pkg::SEL_MEM);
   assign hit_gpio  = (region == soc_pkg::SEL_GPIO);
   assign hit_timer = (region == soc_pkg::SEL_TIMER);

   always_comb begin
      o_dmem      = i_dbus;
      o_dmem.cyc  = i_dbus.cyc & hit_mem;
      o_timer     = i_dbus;
      o_timer.cyc = i_dbus.cyc & hit_timer; // Region 3 never reaches the timer
   end

   // GPIO and timer answer here, the RAM supplies its own ack
   always_ff @(posedge i_wb_clk) begin
      if (!i_rst_n) begin
         periph_ack <= 1'b0;
      end else begin
         periph_ack <= i_dbus.cyc & ~hit_mem & ~periph_ack;
      end
   end

   always_ff @(posedge i_wb_clk) begin
      if (!i_rst_n) begin
         gpio_q <= 1'b0;
      end else if (i_dbus.cyc & i_dbus.we & hit_gpio) begin
         gpio_q <= i_dbus.dat[0];
      end
   end

   always_comb begin
      o_dbus.ack = hit_mem ? i_dmem.ack : periph_ack;
      case (region)
         soc_pkg::SEL_MEM: begin
            o_dbus.rdt = i_dmem.rdt;
         end
         soc_pkg::SEL_GPIO: begin
            o_dbus.rdt = {{(wb_pkg::WORD_W-1){1'b0}}, gpio_q};
         end
         default: begin
            o_dbus.rdt = i_timer_rdt; // Timer and the unused top region read mtime
         end
      endcase
   end

   assign o_q = gpio_q;

endmodule

// File: rtl/servant_arbiter.sv
`timescale 1ns/1ps

module servant_arbiter (
   input  wb_pkg::wb_req_t i_ibus,
   output wb_pkg::wb_rsp_t o_ibus,
   input  wb_pkg::wb_req_t i_dmem,
   output wb_pkg::wb_rsp_t o_dmem,
   output wb_pkg::wb_req_t o_mem,
   input  wb_pkg::wb_rsp_t i_mem
);

   logic grant_i;

   assign grant_i = i_ibus.cyc; // Instruction fetch always wins

   always_comb begin
      o_mem.dat = i_dmem.dat; // Fetches never write so the data lanes stay on the data bus
      o_mem.cyc = i_ibus.cyc | i_dmem.cyc;
      if (grant_i) begin
         o_mem.adr = i_ibus.adr;
         o_mem.sel = '1;
         o_mem.we  = 1'b0;
      end else begin
         o_mem.adr = i_dmem.adr;
         o_mem.sel = i_dmem.sel;
         o_mem.we  = i_dmem.we;
      end
   end

   always_comb begin
      o_ibus.rdt = i_mem.rdt;
      o_ibus.ack = i_mem.ack & grant_i;
      o_dmem.rdt = i_mem.rdt;
      o_dmem.ack = i_mem.ack & ~grant_i;
   end

endmodule

// File: rtl/soc_pkg.sv
package soc_pkg;

   localparam int MEM_BYTES = 8192;
   localparam int MEM_AW    = $clog2(MEM_BYTES);
   localparam int MEM_WORDS = MEM_BYTES / 4;

   // Region codes on adr[31:30]
   localparam logic [1:0] SEL_MEM   = 2'd0;
   localparam logic [1:0] SEL_GPIO  = 2'd1;
   localparam logic [1:0] SEL_TIMER = 2'd2;

   localparam int TIMER_W = 32;

   // Compare value that keeps the interrupt quiet until software sets it
   localparam logic [TIMER_W-1:0] MTIMECMP_RST = '1;

endpackage

// File: rtl/wb_pkg.sv
package wb_pkg;

   localparam int WORD_W = 32;
   localparam int SEL_W  = 4;
   localparam int BYTE_W = WORD_W / SEL_W;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [SEL_W-1:0]  sel_t;

   // Master to slave, fields are held stable while cyc is high
   typedef struct packed {
      word_t adr;
      word_t dat;
      sel_t  sel;
      logic  we;
      logic  cyc;
   } wb_req_t;

   // Slave to master, rdt is only meaningful while ack is high
   typedef struct packed {
      word_t rdt;
      logic  ack;
   } wb_rsp_t;

endpackage
